// File: alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Data path width of the execute path
// Decode still assumes the RV32 instruction encodings
`define XLEN 32

// Destination tag carried alongside each item, wide enough for x0..x31
`define TAG_W 5

// Shift amount taken from the low bits of the second operand
`define SHAMT_W 5

`endif

// File: alu_decode.sv
`include "alu_config.svh"

module alu_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  alu_pkg::issue_t      issue,
    output logic                 dec_valid,
    input  logic                 dec_ready,
    output alu_pkg::alu_inputs_t dec_out
);
    import alu_pkg::*;

    logic [6:0]       opcode;  // Instruction fields
    logic [6:0]       funct7;
    fn3_t             fn3;
    logic             is_op;
    logic             is_imm;
    logic             f7_ok;   // funct7 is a legal encoding for this funct3
    logic [`XLEN-1:0] imm;     // Sign-extended I-immediate
    logic [`XLEN-1:0] operand2;
    logic             ext_sign; // Signed extension of the operands for SLT only
    logic             new_request;
    alu_inputs_t      dec_next;

    assign opcode = issue.instr[6:0];
    assign funct7 = issue.instr[31:25];
    assign fn3    = fn3_t'(issue.instr[14:12]);
    assign is_op  = (opcode == OP);
    assign is_imm = (opcode == OP_IMM);
    assign imm    = {{(`XLEN-12){issue.instr[31]}}, issue.instr[31:20]};

    assign operand2 = is_op ? issue.rs2 : imm; // OP-IMM takes the immediate as in2
    assign ext_sign = (fn3 == SLT_fn3);

    // Legal funct7 values depend on funct3 and on the opcode group
    always_comb begin
        case (fn3)
            SLL_fn3 : f7_ok = (funct7 == 7'b0000000);       // SLL and SLLI alike
            SR_fn3  : f7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            ADD_fn3 : f7_ok = is_imm || (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            default : f7_ok = is_imm || (funct7 == 7'b0000000); // Immediate bits for OP-IMM
        endcase
    end

    always_comb begin
        dec_next.in1 = {ext_sign & issue.rs1[`XLEN-1], issue.rs1};
        dec_next.in2 = {ext_sign & operand2[`XLEN-1], operand2};
        // SLT/SLTU read the borrow, SUB only exists in the OP group
        dec_next.subtract = (fn3 == SLT_fn3) || (fn3 == SLTU_fn3) ||
                            (is_op && (fn3 == ADD_fn3) && issue.instr[30]);
        dec_next.arith    = (fn3 == SR_fn3) && issue.instr[30]; // SRA, SRAI
        dec_next.lshift   = (fn3 == SLL_fn3);
        dec_next.fn3      = fn3;
        case (fn3)
            ADD_fn3           : dec_next.op = ALU_ADD_SUB;
            SLL_fn3, SR_fn3   : dec_next.op = ALU_SHIFT;
            SLT_fn3, SLTU_fn3 : dec_next.op = ALU_SLT;
            default           : dec_next.op = ALU_LOGIC; // XOR, OR, AND
        endcase
        // Unknown opcode or funct7 is flagged, the ALU stage zeroes the result
        dec_next.illegal = !(is_op || is_imm) || !f7_ok;
        dec_next.tag     = issue.tag;
    end

    // Take a new item when empty or when the held one leaves this cycle
    assign issue_ready = ~dec_valid | (dec_valid & dec_ready);
    assign new_request = issue_valid & issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (new_request) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0; // Held item went downstream with nothing behind it
        end
    end

    // Payload register, only meaningful while dec_valid is high
    always_ff @(posedge clk) begin
        if (new_request) begin
            dec_out <= dec_next;
        end
    end

    // Decoded item must hold still until the ALU stage takes it
    dec_out_stable : assert property (@(posedge clk) disable iff (rst)
        (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_out)))
        else $error("decode output changed while stalled");

endmodule

// File: alu_pipeline_top.sv
`include "alu_config.svh"

module alu_pipeline_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  alu_pkg::issue_t      issue,
    output logic                 result_valid,
    input  logic                 result_ready,
    output alu_pkg::alu_result_t result
);
    import alu_pkg::*;

    logic        dec_valid;  // Decode to ALU boundary
    logic        dec_ready;
    alu_inputs_t dec_out;
    logic        ex_valid;   // ALU to writeback boundary
    logic        ex_ready;
    alu_result_t ex_out;

    alu_decode alu_decode_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_out     (dec_out)
    );

    alu_unit alu_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_out   (dec_out),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .ex_out    (ex_out)
    );

    // Final stage drives the top-level result port directly
    alu_writeback alu_writeback_inst (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_ready     (ex_ready),
        .ex_out       (ex_out),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

endmodule

// File: alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

    // Result select for the ALU output mux
    typedef enum logic [1:0] {
        ALU_ADD_SUB,
        ALU_LOGIC,
        ALU_SLT,
        ALU_SHIFT
    } alu_op_t;

    // RV32I funct3 codes of the OP and OP-IMM groups
    typedef enum logic [2:0] {
        ADD_fn3  = 3'b000, // ADD/SUB, ADDI
        SLL_fn3  = 3'b001,
        SLT_fn3  = 3'b010,
        SLTU_fn3 = 3'b011,
        XOR_fn3  = 3'b100,
        SR_fn3   = 3'b101, // SRL/SRA, funct7 bit 5 picks arithmetic
        OR_fn3   = 3'b110,
        AND_fn3  = 3'b111
    } fn3_t;

    // Major opcodes handled by this path, anything else is illegal
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // Register-register
        OP_IMM = 7'b0010011  // Register-immediate
    } opcode_t;

    // One request as it enters the pipeline
    typedef struct packed {
        logic [31:0]        instr; // Raw instruction word
        logic [`XLEN-1:0]   rs1;   // Source register values, read elsewhere
        logic [`XLEN-1:0]   rs2;
        logic [`TAG_W-1:0]  tag;   // Destination tag, passed through untouched
    } issue_t;

    // Decoded operands and controls handed to the ALU stage
    typedef struct packed {
        logic [`XLEN:0]     in1;      // Top bit is the sign or zero extension for SLT/SLTU
        logic [`XLEN:0]     in2;
        logic               subtract; // SUB, SLT and SLTU use the subtractor
        logic               arith;    // Sign fill for SRA/SRAI
        logic               lshift;   // Left shift for SLL/SLLI
        fn3_t               fn3;
        alu_op_t            op;
        logic               illegal;
        logic [`TAG_W-1:0]  tag;
    } alu_inputs_t;

    // Finished result with its tag
    typedef struct packed {
        logic [`XLEN-1:0]   rd;
        logic [`TAG_W-1:0]  tag;
        logic               illegal; // rd is zero when set
    } alu_result_t;

endpackage

// File: alu_unit.sv
`include "alu_config.svh"

module alu_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    output logic                 dec_ready,
    input  alu_pkg::alu_inputs_t dec_out,
    output logic                 ex_valid,
    input  logic                 ex_ready,
    output alu_pkg::alu_result_t ex_out
);
    import alu_pkg::*;

    alu_inputs_t      alu_inputs;     // Operation held for the writeback stage
    logic             done;           // A finished result is waiting
    logic             accepted;       // Writeback takes the result this cycle
    logic             new_request;
    logic [`XLEN:0]   add_sub_result; // Extra bit gives the SLT/SLTU answer
    logic [`XLEN-1:0] logic_result;
    logic [`XLEN-1:0] shifter_result;
    logic [`XLEN-1:0] rd;

    // The handshake of this stage follows the issue/accept pattern
    assign accepted    = done & ex_ready;
    assign dec_ready   = ~done | accepted;
    assign new_request = dec_valid & dec_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (new_request) begin
            done <= 1'b1; // Back-to-back items keep done set
        end else if (accepted) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (new_request) begin
            alu_inputs <= dec_out;
        end
    end

    // Operands arrive already extended, so one subtractor serves SLT and SLTU
    assign add_sub_result = alu_inputs.subtract ? alu_inputs.in1 - alu_inputs.in2
                                                : alu_inputs.in1 + alu_inputs.in2;

    always_comb begin
        case (alu_inputs.fn3)
            XOR_fn3 : logic_result = alu_inputs.in1[`XLEN-1:0] ^ alu_inputs.in2[`XLEN-1:0];
            OR_fn3  : logic_result = alu_inputs.in1[`XLEN-1:0] | alu_inputs.in2[`XLEN-1:0];
            default : logic_result = alu_inputs.in1[`XLEN-1:0] & alu_inputs.in2[`XLEN-1:0];
        endcase
    end

    barrel_shifter shifter (
        .shifter_input  (alu_inputs.in1[`XLEN-1:0]),
        .shift_amount   (alu_inputs.in2[`SHAMT_W-1:0]), // Upper immediate bits are ignored
        .arith          (alu_inputs.arith),
        .lshift         (alu_inputs.lshift),
        .shifted_result (shifter_result)
    );

    // Result mux
    always_comb begin
        case (alu_inputs.op)
            ALU_ADD_SUB : rd = add_sub_result[`XLEN-1:0];
            ALU_LOGIC   : rd = logic_result;
            ALU_SLT     : rd = {{(`XLEN-1){1'b0}}, add_sub_result[`XLEN]};
            default     : rd = shifter_result; // ALU_SHIFT
        endcase
        if (alu_inputs.illegal) begin
            rd = '0; // Illegal items leave with a zero result
        end
    end

    assign ex_valid       = done;
    assign ex_out.rd      = rd;
    assign ex_out.tag     = alu_inputs.tag;
    assign ex_out.illegal = alu_inputs.illegal;

    // A waiting result must not be overwritten by a new item
    held_until_accepted : assert property (@(posedge clk) disable iff (rst)
        (done && !ex_ready) |=> (done && $stable(alu_inputs)))
        else $error("ALU item replaced before writeback accepted it");

endmodule

// File: alu_writeback.sv
`include "alu_config.svh"

module alu_writeback (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    output logic                 ex_ready,
    input  alu_pkg::alu_result_t ex_out,
    output logic                 result_valid,
    input  logic                 result_ready,
    output alu_pkg::alu_result_t result
);

    logic load; // ALU result transfers into the output register

    // Accepting here is what releases the ALU stage
    assign ex_ready = ~result_valid | (result_valid & result_ready);
    assign load     = ex_valid & ex_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (load) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0; // Consumer took the last item
        end
    end

    // Registered copy cuts the ALU's combinational path from the consumer
    always_ff @(posedge clk) begin
        if (load) begin
            result <= ex_out;
        end
    end

    // The consumer sees one steady value until it takes it
    result_stable : assert property (@(posedge clk) disable iff (rst)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)))
        else $error("result changed under back-pressure");

endmodule

// File: barrel_shifter.sv
`include "alu_config.svh"

module barrel_shifter (
    input  logic [`XLEN-1:0]    shifter_input,
    input  logic [`SHAMT_W-1:0] shift_amount,
    input  logic                arith,
    input  logic                lshift,
    output logic [`XLEN-1:0]    shifted_result
);

    logic [`XLEN-1:0] shift_in;  // Input, bit-reversed for left shifts
    logic [`XLEN:0]   extended;  // One extra bit carries the fill value
    logic [`XLEN-1:0] shift_out; // Output of the single right shifter

    // Reversing the bits turns a left shift into a right shift
    always_comb begin
        for (int i = 0; i < `XLEN; i++) begin
            shift_in[i] = lshift ? shifter_input[`XLEN-1-i] : shifter_input[i];
        end
    end

    // Fill with the sign bit for SRA, zeros otherwise
    assign extended  = {arith & shift_in[`XLEN-1], shift_in};
    assign shift_out = `XLEN'($signed(extended) >>> shift_amount);

    // Undo the reversal on the way out
    always_comb begin
        for (int i = 0; i < `XLEN; i++) begin
            shifted_result[i] = lshift ? shift_out[`XLEN-1-i] : shift_out[i];
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU pipeline testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
    --top-module tb_alu_pipeline -f sources.f -o sim_alu 2>&1 | tee build.log \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_alu 2>&1 | tee sim.log

# The log decides the verdict
grep -q "CHECKS FAILED" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
    || { echo "Simulation ended without a verdict, see sim.log"; exit 1; }

echo "Simulation passed"
exit 0

// File: sources.f
+incdir+.
alu_pkg.sv
barrel_shifter.sv
alu_decode.sv
alu_unit.sv
alu_writeback.sv
alu_pipeline_top.sv
tb_alu_pipeline.sv

// File: tb_alu_pipeline.sv
`include "alu_config.svh"

module tb_alu_pipeline;
    import alu_pkg::*;

    localparam int          TIMEOUT = 200;           // Cycles a single wait may take
    localparam logic [31:0] SEED    = 32'h8321a2af;
    localparam logic [6:0]  OPC_OP  = 7'b0110011;    // RV32I major opcodes
    localparam logic [6:0]  OPC_IMM = 7'b0010011;

    logic              clk;
    logic              rst;
    logic              issue_valid;
    logic              issue_ready;
    issue_t            issue;
    logic              result_valid;
    logic              result_ready;
    alu_result_t       result;

    integer            seed;               // Stimulus stream
    integer            ready_seed;         // Consumer stall stream, kept apart from stimulus
    logic              random_ready = 1'b0; // Consumer stalls at random when set
    int                cycle = 0;
    int                first_issue_cycle = 0;
    int                issued = 0;
    int                received = 0;
    logic [`TAG_W-1:0] next_tag = '0;
    alu_result_t       exp_q[$];           // Expected results in issue order
    logic              held_valid = 1'b0;  // Last edge saw result waiting under back-pressure
    alu_result_t       held_result;

    alu_pipeline_top alu_pipeline_top_inst (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1; // Edge counter for latency
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_run($sformatf("ERR @%0t: %s, got %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    // Expected result straight from the RV32I rules for OP and OP-IMM
    function automatic alu_result_t ref_alu(input issue_t req);
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [4:0]       sh;
        logic             legal;
        alu_result_t      r;
        opc = req.instr[6:0];
        f3  = req.instr[14:12];
        f7  = req.instr[31:25];
        a   = req.rs1;
        b   = (opc == OPC_OP) ? req.rs2 : {{(`XLEN-12){req.instr[31]}}, req.instr[31:20]};
        sh  = b[4:0];
        if (opc == OPC_OP) begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == OPC_IMM) begin
            if (f3 == 3'd1) legal = (f7 == 7'h00);        // SLLI
            else if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20); // SRLI, SRAI
            else legal = 1'b1;                            // Whole field is immediate
        end else begin
            legal = 1'b0;
        end
        case (f3)
            3'd0: r.rd = (opc == OPC_OP && f7[5]) ? a - b : a + b;
            3'd1: r.rd = a << sh;
            3'd2: r.rd = ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
            3'd3: r.rd = (a < b) ? `XLEN'd1 : `XLEN'd0;
            3'd4: r.rd = a ^ b;
            3'd5: begin
                if (f7[5]) begin
                    r.rd = $signed(a) >>> sh; // Sign fill for SRA and SRAI
                end else begin
                    r.rd = a >> sh;
                end
            end
            3'd6: r.rd = a | b;
            default: r.rd = a & b;
        endcase
        if (!legal) r.rd = '0;
        r.tag     = req.tag;
        r.illegal = !legal;
        return r;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'($random(seed)), 5'($random(seed)), f3, 5'($random(seed)), OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'($random(seed)), f3, 5'($random(seed)), OPC_IMM};
    endfunction

    // Mostly legal words, with stray opcodes and bad funct7 mixed in
    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        logic [2:0]  pick;
        word = $random(seed);
        pick = 3'($random(seed));
        if (pick <= 3'd2) begin
            word[6:0]   = OPC_OP;
            word[31:25] = {1'b0, word[30], 5'b0};
        end else if (pick <= 3'd5) begin
            word[6:0] = OPC_IMM;
            if (word[14:12] == 3'd1) word[31:25] = 7'h00;
            else if (word[14:12] == 3'd5) word[31:25] = {1'b0, word[30], 5'b0};
        end else if (pick == 3'd7) begin
            word[6:0] = OPC_OP; // Random funct7, usually illegal
        end
        return word;
    endfunction

    // Holds the request on the port until the DUT takes it
    task automatic send(input logic [31:0] instr, input logic [`XLEN-1:0] a,
                        input logic [`XLEN-1:0] b);
        issue_t req;
        int     waited;
        req.instr = instr;
        req.rs1   = a;
        req.rs2   = b;
        req.tag   = next_tag;
        issue_valid <= 1'b1;
        issue       <= req;
        waited = 0;
        @(posedge clk);
        while (!issue_ready) begin
            if (waited == TIMEOUT) stop_run("Timed out waiting for issue_ready to rise");
            waited++;
            @(posedge clk);
        end
        if (issued == 0) first_issue_cycle = cycle;
        exp_q.push_back(ref_alu(req));
        issued++;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (received != issued) begin
            if (waited == TIMEOUT) stop_run("Timed out waiting for the pipeline to drain");
            waited++;
            @(posedge clk);
        end
    endtask

    // Consumer side, ready high or random depending on the phase
    initial begin
        ready_seed   = SEED;
        result_ready = 1'b0;
        forever begin
            @(posedge clk);
            result_ready <= random_ready ? 1'($random(ready_seed)) : 1'b1;
        end
    end

    // Compares every result transfer against the queue head
    always @(posedge clk) begin
        if (!rst) begin
            if (held_valid) begin
                check_equal(64'(result_valid), 64'd1, "result_valid dropped while stalled");
                check_equal(64'(result), 64'(held_result), "result changed while stalled");
            end
            held_valid  = result_valid && !result_ready;
            held_result = result;
            if (result_valid && result_ready) begin
                if (exp_q.size() == 0) stop_run("A result arrived with no issue to match it");
                if (received == 0) begin
                    check_equal(64'(cycle - first_issue_cycle), 64'd3, "first result latency");
                end
                check_equal(64'(result), 64'(exp_q.pop_front()),
                            $sformatf("result of item %0d", received));
                received++;
            end
        end
    end

    initial begin
        logic [`XLEN-1:0] edges [5];
        logic [9:0]       op_list [10]; // funct7 and funct3 of each OP instruction
        logic [11:0]      imms [5];
        logic [2:0]       imm_fn3 [6];
        logic [4:0]       shamts [4];
        logic [9:0]       sh_list [3];
        seed        = SEED;
        edges       = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h1};
        op_list     = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2},
                        {7'h00, 3'd3}, {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5},
                        {7'h00, 3'd6}, {7'h00, 3'd7}};
        imms        = '{12'h000, 12'hfff, 12'h800, 12'h7ff, 12'h001};
        imm_fn3     = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        shamts      = '{5'd0, 5'd31, 5'd1, 5'd16};
        sh_list     = '{{7'h00, 3'd1}, {7'h00, 3'd5}, {7'h20, 3'd5}}; // SLLI SRLI SRAI
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_equal(64'(result_valid), 64'd0, "result_valid after reset");
        check_equal(64'(issue_ready), 64'd1, "issue_ready after reset");

        // Register-register group, edge operands then random ones, issued back to back
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) send(r_type(op_list[k][9:3], op_list[k][2:0]),
                                                 edges[i], edges[j]);
            end
            repeat (8) send(r_type(op_list[k][9:3], op_list[k][2:0]),
                            $random(seed), $random(seed));
        end

        // Immediate group, rs2 stays random to show it is ignored
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) send(i_type(imms[j], imm_fn3[k]),
                                                 edges[i], $random(seed));
            end
            repeat (6) send(i_type(12'($random(seed)), imm_fn3[k]),
                            $random(seed), $random(seed));
        end
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 4; j++) send(i_type({sh_list[k][9:3], shamts[j]},
                                                        sh_list[k][2:0]), edges[i], $random(seed));
            end
        end

        // Illegal encodings, other opcodes and bad funct7 values
        send({25'($random(seed)), 7'b0000011}, $random(seed), $random(seed));
        send({25'($random(seed)), 7'b1100011}, $random(seed), $random(seed));
        send({25'($random(seed)), 7'b0110111}, $random(seed), $random(seed));
        send(32'h0, $random(seed), $random(seed));
        send(r_type(7'h01, 3'd0), $random(seed), $random(seed)); // MUL is not supported
        send(r_type(7'h20, 3'd4), $random(seed), $random(seed));
        send(r_type(7'h20, 3'd1), $random(seed), $random(seed));
        send(i_type({7'h20, 5'd3}, 3'd1), $random(seed), $random(seed));
        send(i_type({7'h01, 5'd3}, 3'd5), $random(seed), $random(seed));
        issue_valid <= 1'b0;
        wait_drain();

        // Random consumer stalls and random gaps between issues
        random_ready = 1'b1;
        repeat (400) begin
            send(random_instr(), $random(seed), $random(seed));
            if (3'($random(seed)) == 3'd0) begin
                issue_valid <= 1'b0;
                @(posedge clk);
            end
        end
        issue_valid <= 1'b0;
        wait_drain();

        $display("%0d results checked", received);
        if (exp_q.size() == 0 && received == issued) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run("Results were left unmatched at the end of the run");
        end
    end

endmodule
